// File: verilog/tag_pkg.sv
`default_nettype none

package tag_pkg;

  //////////////////////////////////////////////////////////////////////
  // Field widths

  localparam int TAG_DID_WIDTH       = 4;
  localparam int TAG_CLIENT_ID_WIDTH = 2;
  localparam int TAG_PAYLOAD_WIDTH   = TAG_DID_WIDTH + 1;
  localparam int TAG_OP_WIDTH        = 2;
  localparam int TAG_ENTRY_WIDTH     = TAG_OP_WIDTH + TAG_CLIENT_ID_WIDTH + 1 + TAG_PAYLOAD_WIDTH;

  // Start bit, client id, data-not-reset, payload
  localparam int TAG_PACKET_LEN = 1 + TAG_CLIENT_ID_WIDTH + 1 + TAG_PAYLOAD_WIDTH;

  // Opcode sits on top, the rest of an entry is the packet body
  localparam int TAG_OP_LSB = TAG_ENTRY_WIDTH - TAG_OP_WIDTH;

  // Reset request is the top payload bit
  localparam int TAG_PAYLOAD_RESET_BIT = TAG_PAYLOAD_WIDTH - 1;

  //////////////////////////////////////////////////////////////////////
  // Types

  typedef logic [TAG_DID_WIDTH-1:0]       tag_did_t;
  typedef logic [TAG_CLIENT_ID_WIDTH-1:0] tag_client_id_t;
  typedef logic [TAG_PAYLOAD_WIDTH-1:0]   tag_payload_t;

  // {op, client id, dnr, payload}
  typedef logic [TAG_ENTRY_WIDTH-1:0]     tag_trace_entry_t;

  typedef enum logic [TAG_OP_WIDTH-1:0]
  {
    op_nop    = 2'b00,
    op_send   = 2'b01,
    op_wait   = 2'b10,
    op_finish = 2'b11
  } tag_op_e;

  typedef enum logic [1:0]
  {
    rp_idle,
    rp_send,
    rp_wait,
    rp_done
  } replay_state_e;

endpackage

`default_nettype wire

// File: verilog/tag_trace_replay.sv
`default_nettype none

module tag_trace_replay
  (
    input  logic                      tag_clk_i,
    input  logic                      rst_n_i,

    input  logic                      trace_v_i,
    input  tag_pkg::tag_trace_entry_t trace_data_i,
    output logic                      trace_ready_o,

    output logic                      tag_data_o,
    output logic                      tag_en_o,
    output logic                      done_o
  );

  import tag_pkg::*;

  localparam int cnt_w_lp = $clog2(TAG_PACKET_LEN + 1);
  localparam logic [cnt_w_lp-1:0] pkt_len_lp = cnt_w_lp'(TAG_PACKET_LEN);

  replay_state_e             state_r;
  tag_op_e                   op;
  logic                      accept;
  logic [TAG_PACKET_LEN-1:0] pkt_sh_r;
  logic [cnt_w_lp-1:0]       bit_cnt_r;
  tag_payload_t              wait_cnt_r;
  logic                      tag_data_r;
  logic                      tag_en_r;

  assign op            = tag_op_e'(trace_data_i[TAG_OP_LSB +: TAG_OP_WIDTH]);
  assign trace_ready_o = (state_r == rp_idle);
  assign accept        = trace_v_i & trace_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Entry decode and sequencing

  always_ff @(posedge tag_clk_i or negedge rst_n_i)
    if (!rst_n_i)
      begin
        state_r    <= rp_idle;
        bit_cnt_r  <= '0;
        wait_cnt_r <= '0;
        tag_en_r   <= 1'b0;
        tag_data_r <= 1'b0;
      end
    else
      case (state_r)
        rp_idle:
          if (accept)
            case (op)
              op_send:
                begin
                  state_r   <= rp_send;
                  bit_cnt_r <= pkt_len_lp;
                end
              op_wait:
                begin
                  state_r    <= rp_wait;
                  wait_cnt_r <= trace_data_i[TAG_PAYLOAD_WIDTH-1:0];
                end
              // A nop is a zero-length wait
              op_nop:
                begin
                  state_r    <= rp_wait;
                  wait_cnt_r <= '0;
                end
              default:
                state_r <= rp_done;
            endcase
        rp_send:
          if (bit_cnt_r != '0)
            begin
              tag_en_r   <= 1'b1;
              tag_data_r <= pkt_sh_r[TAG_PACKET_LEN-1];
              bit_cnt_r  <= bit_cnt_r - 1'b1;
            end
          else
            begin
              tag_en_r   <= 1'b0;
              tag_data_r <= 1'b0;
              state_r    <= rp_idle;
            end
        rp_wait:
          if (wait_cnt_r == '0)
            state_r <= rp_idle;
          else
            wait_cnt_r <= wait_cnt_r - 1'b1;
        default:
          state_r <= rp_done;
      endcase

  // Packet shifter sends the MSB first
  always_ff @(posedge tag_clk_i)
    if (accept && (op == op_send))
      pkt_sh_r <= {1'b1, trace_data_i[TAG_OP_LSB-1:0]};
    else if (state_r == rp_send)
      pkt_sh_r <= {pkt_sh_r[TAG_PACKET_LEN-2:0], 1'b0};

  assign tag_data_o = tag_data_r;
  assign tag_en_o   = tag_en_r;
  assign done_o     = (state_r == rp_done);

endmodule

`default_nettype wire

// File: verilog/tag_master.sv
`default_nettype none

module tag_master
  #(parameter int num_clients_p = 3)
  (
    input  logic                     tag_clk_i,
    input  logic                     rst_n_i,

    input  logic                     tag_data_i,
    input  logic                     tag_en_i,

    output logic [num_clients_p-1:0] client_v_o,
    output logic                     client_dnr_o,
    output tag_pkg::tag_payload_t    client_payload_o
  );

  import tag_pkg::*;

  localparam int body_w_lp = TAG_PACKET_LEN - 1;
  localparam int pos_w_lp  = $clog2(TAG_PACKET_LEN);
  localparam logic [pos_w_lp-1:0] last_pos_lp = pos_w_lp'(body_w_lp);

  logic [pos_w_lp-1:0]      pos_r;
  logic                     discard_r;
  logic [body_w_lp-2:0]     body_sh_r;
  logic [body_w_lp-1:0]     body;
  logic                     last_bit;
  tag_client_id_t           pkt_cid;
  logic [num_clients_p-1:0] client_v_n;
  logic [num_clients_p-1:0] client_v_r;
  logic                     dnr_r;
  tag_payload_t             payload_r;

  // Body completes with the bit on the wire this cycle
  assign body     = {body_sh_r, tag_data_i};
  assign pkt_cid  = body[body_w_lp-1 -: TAG_CLIENT_ID_WIDTH];
  assign last_bit = tag_en_i & ~discard_r & (pos_r == last_pos_lp);

  // Ids past the last client match nothing
  always_comb
    begin
      client_v_n = '0;
      for (int i = 0; i < num_clients_p; i++)
        client_v_n[i] = last_bit & (pkt_cid == tag_client_id_t'(i));
    end

  //////////////////////////////////////////////////////////////////////
  // Deframer

  always_ff @(posedge tag_clk_i or negedge rst_n_i)
    if (!rst_n_i)
      begin
        pos_r      <= '0;
        discard_r  <= 1'b0;
        client_v_r <= '0;
      end
    else
      begin
        client_v_r <= client_v_n;
        if (!tag_en_i)
          begin
            pos_r     <= '0;
            discard_r <= 1'b0;
          end
        else if (!discard_r)
          if (pos_r == '0)
            if (tag_data_i)
              pos_r <= pos_r + 1'b1;
            else
              discard_r <= 1'b1;   // bad start bit drops the rest
          else if (last_bit)
            pos_r <= '0;
          else
            pos_r <= pos_r + 1'b1;
      end

  always_ff @(posedge tag_clk_i)
    begin
      if (tag_en_i && !discard_r && (pos_r != '0))
        body_sh_r <= body[body_w_lp-2:0];
      if (last_bit)
        begin
          dnr_r     <= body[TAG_PAYLOAD_WIDTH];
          payload_r <= body[TAG_PAYLOAD_WIDTH-1:0];
        end
    end

  assign client_v_o       = client_v_r;
  assign client_dnr_o     = dnr_r;
  assign client_payload_o = payload_r;

endmodule

`default_nettype wire

// File: verilog/tag_client.sv
`default_nettype none

module tag_client
  (
    input  logic                  tag_clk_i,
    input  logic                  rst_n_i,

    input  logic                  recv_v_i,
    input  logic                  recv_dnr_i,
    input  tag_pkg::tag_payload_t recv_payload_i,
    input  logic                  done_i,

    output logic                  reset_o,
    output tag_pkg::tag_did_t     did_o,
    output logic                  new_o
  );

  import tag_pkg::*;

  tag_payload_t data_r;
  logic         new_r;

  always_ff @(posedge tag_clk_i or negedge rst_n_i)
    if (!rst_n_i)
      begin
        data_r <= '0;
        new_r  <= 1'b0;
      end
    else
      begin
        new_r <= recv_v_i;
        if (recv_v_i)
          data_r <= recv_dnr_i ? recv_payload_i : '0;
      end

  // Held in reset until the trace is done
  assign reset_o = data_r[TAG_PAYLOAD_RESET_BIT] | ~done_i;
  assign did_o   = data_r[TAG_DID_WIDTH-1:0];
  assign new_o   = new_r;

endmodule

`default_nettype wire

// File: verilog/tag_gateway.sv
`default_nettype none

module tag_gateway
  #(parameter int num_clients_p = 3)
  (
    input  logic                                 tag_clk_i,
    input  logic                                 rst_n_i,

    input  logic                                 trace_v_i,
    input  tag_pkg::tag_trace_entry_t            trace_data_i,
    output logic                                 trace_ready_o,

    output logic                                 tag_data_o,
    output logic                                 tag_en_o,
    output logic                                 done_o,

    output logic [num_clients_p-1:0]             client_reset_o,
    output tag_pkg::tag_did_t [num_clients_p-1:0] client_did_o,
    output logic [num_clients_p-1:0]             client_new_o
  );

  import tag_pkg::*;

  logic                     tag_data;
  logic                     tag_en;
  logic                     done;
  logic [num_clients_p-1:0] client_v;
  logic                     client_dnr;
  tag_payload_t             client_payload;

  //////////////////////////////////////////////////////////////////////
  // Trace replay

  tag_trace_replay replay
    (
      .tag_clk_i     (tag_clk_i),
      .rst_n_i       (rst_n_i),
      .trace_v_i     (trace_v_i),
      .trace_data_i  (trace_data_i),
      .trace_ready_o (trace_ready_o),
      .tag_data_o    (tag_data),
      .tag_en_o      (tag_en),
      .done_o        (done)
    );

  assign tag_data_o = tag_data;
  assign tag_en_o   = tag_en;
  assign done_o     = done;

  //////////////////////////////////////////////////////////////////////
  // Tag master

  tag_master #(.num_clients_p(num_clients_p)) btm
    (
      .tag_clk_i        (tag_clk_i),
      .rst_n_i          (rst_n_i),
      .tag_data_i       (tag_data),
      .tag_en_i         (tag_en),
      .client_v_o       (client_v),
      .client_dnr_o     (client_dnr),
      .client_payload_o (client_payload)
    );

  //////////////////////////////////////////////////////////////////////
  // Client 0 is the core, 1 the host and 2 the router

  for (genvar i = 0; i < num_clients_p; i++)
    begin : g_client
      tag_client btc
        (
          .tag_clk_i      (tag_clk_i),
          .rst_n_i        (rst_n_i),
          .recv_v_i       (client_v[i]),
          .recv_dnr_i     (client_dnr),
          .recv_payload_i (client_payload),
          .done_i         (done),
          .reset_o        (client_reset_o[i]),
          .did_o          (client_did_o[i]),
          .new_o          (client_new_o[i])
        );
    end

endmodule

`default_nettype wire

// File: test/tb_tag_gateway.sv
`default_nettype none

module tb_tag_gateway;

  timeunit 1ns;
  timeprecision 100ps;

  import tag_pkg::*;

  localparam int num_clients_lp = 3;
  localparam int case_cycles_lp = 45;
  localparam int ready_limit_lp = 40;
  // Client outputs change after edge k+11 for a send taken at edge k
  localparam int new_cycle_lp   = TAG_PACKET_LEN + 2;

  logic                          clk;
  logic                          rst_n;
  logic                          trace_v;
  tag_trace_entry_t              trace_data;
  logic                          trace_ready;
  logic                          tag_data;
  logic                          tag_en;
  logic                          done;
  logic [num_clients_lp-1:0]     client_reset;
  tag_did_t [num_clients_lp-1:0] client_did;
  logic [num_clients_lp-1:0]     client_new;

  tag_payload_t     model_pl [num_clients_lp];
  logic             model_done;
  tag_trace_entry_t case_entry_q [$];
  string            case_tag_q [$];
  logic [31:0]      rnd_state;
  int               err_cnt;
  int               pass_cnt;
  int               fail_cnt;
  int               cycle_cnt = 0;
  int               cycle_limit = 0;

  tag_gateway #(.num_clients_p(num_clients_lp)) dut_i
    (
      .tag_clk_i      (clk),
      .rst_n_i        (rst_n),
      .trace_v_i      (trace_v),
      .trace_data_i   (trace_data),
      .trace_ready_o  (trace_ready),
      .tag_data_o     (tag_data),
      .tag_en_o       (tag_en),
      .done_o         (done),
      .client_reset_o (client_reset),
      .client_did_o   (client_did),
      .client_new_o   (client_new)
    );

  initial
    clk = 1'b0;

  always #50 clk = ~clk;

  always @(posedge clk)
    begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
          $display("timeout: run still going after %0d cycles", cycle_cnt);
          $display("test failed");
          $finish;
        end
    end

  //////////////////////////////////////////////////////////////////////
  // Checks against the reference model

  task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v)
      begin
        $display("mismatch at %0t: %s expected %b got %b", $time, name, exp_v, act_v);
        err_cnt++;
      end
  endtask

  task automatic compare_did(input string name, input tag_did_t exp_v, input tag_did_t act_v);
    if (act_v !== exp_v)
      begin
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
        err_cnt++;
      end
  endtask

  task automatic check_clients();
    logic exp_rst;
    for (int i = 0; i < num_clients_lp; i++)
      begin
        // Reset held until done, then the stored reset bit
        exp_rst = model_done ? model_pl[i][TAG_PAYLOAD_RESET_BIT] : 1'b1;
        compare_bit($sformatf("client_reset_o[%0d]", i), exp_rst, client_reset[i]);
        compare_did($sformatf("client_did_o[%0d]", i), model_pl[i][TAG_DID_WIDTH-1:0],
                    client_did[i]);
      end
  endtask

  task automatic check_new(input int pulse_idx);
    for (int i = 0; i < num_clients_lp; i++)
      if (i == pulse_idx && client_new[i] !== 1'b1)
        begin
          $display("client %0d gave no new pulse at %0t", i, $time);
          err_cnt++;
        end
      else
        compare_bit($sformatf("client_new_o[%0d]", i), i == pulse_idx, client_new[i]);
  endtask

  task automatic finish_case(input string label, input int errs_before);
    if (err_cnt == errs_before)
      begin
        pass_cnt++;
        $display("%s: ok", label);
      end
    else
      begin
        fail_cnt++;
        $display("%s: failed with %0d errors", label, err_cnt - errs_before);
      end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string expected_kind(input tag_trace_entry_t entry);
    tag_op_e        op;
    tag_client_id_t cid;
    op  = tag_op_e'(entry[TAG_OP_LSB +: TAG_OP_WIDTH]);
    cid = entry[TAG_OP_LSB-1 -: TAG_CLIENT_ID_WIDTH];
    case (op)
      op_nop:  return "nop";
      op_wait: return "wait";
      op_send:
        if (int'(cid) >= num_clients_lp)
          return "drop";
        else if (entry[TAG_PAYLOAD_WIDTH])
          return "upd";
        else
          return "clr";
      default: return "done";
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic read_cases();
    int               fd;
    int               n;
    string            line_s;
    string            tag_s;
    tag_trace_entry_t entry_v;
    fd = $fopen("test/tag_cases.txt", "r");
    if (fd == 0)
      begin
        $display("cannot open test/tag_cases.txt");
        fail_cnt++;
      end
    else
      begin
        while (!$feof(fd))
          begin
            n = $fgets(line_s, fd);
            if (n > 0)
              n = $sscanf(line_s, "%h %s", entry_v, tag_s);
            // Comment and blank lines do not match
            if (n == 2)
              begin
                case_entry_q.push_back(entry_v);
                case_tag_q.push_back(tag_s);
              end
          end
        $fclose(fd);
      end
  endtask

  // Returns with the acceptance edge just passed when taken
  task automatic offer_entry(input tag_trace_entry_t entry, output logic taken);
    int waited;
    taken  = 1'b0;
    waited = 0;
    @(posedge clk);
    trace_v    <= 1'b1;
    trace_data <= entry;
    while (!taken && waited < ready_limit_lp)
      begin
        @(negedge clk);
        if (trace_ready === 1'b1)
          taken = 1'b1;
        else
          waited++;
      end
    @(posedge clk);
    trace_v <= 1'b0;
  endtask

  task automatic run_send(input tag_trace_entry_t entry);
    logic [TAG_PACKET_LEN-1:0] pkt;
    tag_client_id_t            cid;
    logic                      dnr;
    tag_payload_t              pl;
    int                        hit;
    cid = entry[TAG_OP_LSB-1 -: TAG_CLIENT_ID_WIDTH];
    dnr = entry[TAG_PAYLOAD_WIDTH];
    pl  = entry[TAG_PAYLOAD_WIDTH-1:0];
    pkt = {1'b1, cid, dnr, pl};
    hit = (int'(cid) < num_clients_lp) ? int'(cid) : -1;
    for (int j = 0; j <= new_cycle_lp + 1; j++)
      begin
        @(negedge clk);
        compare_bit("tag_en_o", j >= 1 && j <= TAG_PACKET_LEN, tag_en);
        if (j >= 1 && j <= TAG_PACKET_LEN)
          compare_bit("tag_data_o", pkt[TAG_PACKET_LEN - j], tag_data);
        compare_bit("trace_ready_o", j > TAG_PACKET_LEN, trace_ready);
        if (j == new_cycle_lp && hit >= 0)
          model_pl[hit] = dnr ? pl : '0;
        check_new(j == new_cycle_lp ? hit : -1);
        check_clients();
      end
  endtask

  // Ready stays low for n+1 cycles
  task automatic run_wait(input int n);
    for (int j = 0; j <= n + 1; j++)
      begin
        @(negedge clk);
        compare_bit("trace_ready_o", j == n + 1, trace_ready);
        compare_bit("tag_en_o", 1'b0, tag_en);
        check_new(-1);
      end
  endtask

  task automatic run_finish();
    model_done = 1'b1;
    for (int j = 0; j < 4; j++)
      begin
        @(negedge clk);
        compare_bit("trace_ready_o", 1'b0, trace_ready);
        if (j >= 1)
          begin
            compare_bit("done_o", 1'b1, done);
            check_clients();
          end
      end
  endtask

  task automatic run_case(input int idx, output logic taken);
    tag_trace_entry_t entry;
    string            kind;
    int               errs_before;
    int               gap;
    entry       = case_entry_q[idx];
    kind        = expected_kind(entry);
    errs_before = err_cnt;
    rnd_state   = xorshift32(rnd_state);
    gap         = int'(rnd_state % 32'd4);
    repeat (gap) @(posedge clk);
    if (kind != case_tag_q[idx])
      begin
        $display("case %0d: tag %s does not fit entry %03h", idx, case_tag_q[idx], entry);
        err_cnt++;
      end
    offer_entry(entry, taken);
    if (!taken)
      begin
        $display("case %0d: trace_ready_o never returned, entry %03h not taken", idx, entry);
        err_cnt++;
      end
    else if (kind == "nop")
      run_wait(0);
    else if (kind == "wait")
      run_wait(int'(entry[TAG_PAYLOAD_WIDTH-1:0]));
    else if (kind == "done")
      run_finish();
    else
      run_send(entry);
    finish_case($sformatf("case %0d %s %03h", idx, case_tag_q[idx], entry), errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial
    begin
      logic taken;
      int   errs_before;
      rst_n      <= 1'b0;
      trace_v    <= 1'b0;
      trace_data <= '0;
      err_cnt    = 0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      rnd_state  = 32'h1629;
      model_done = 1'b0;
      for (int i = 0; i < num_clients_lp; i++)
        model_pl[i] = '0;
      read_cases();
      cycle_limit = case_entry_q.size() * case_cycles_lp + 20;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      errs_before = err_cnt;
      @(negedge clk);
      compare_bit("trace_ready_o", 1'b1, trace_ready);
      compare_bit("tag_en_o", 1'b0, tag_en);
      compare_bit("done_o", 1'b0, done);
      check_new(-1);
      check_clients();
      finish_case("after reset", errs_before);

      taken = 1'b1;
      for (int i = 0; i < case_entry_q.size() && taken; i++)
        run_case(i, taken);

      // Done is permanent and the trace input stays closed
      if (taken && model_done)
        begin
          errs_before = err_cnt;
          repeat (8)
            begin
              @(negedge clk);
              compare_bit("done_o", 1'b1, done);
              compare_bit("trace_ready_o", 1'b0, trace_ready);
              check_clients();
            end
          finish_case("hold after finish", errs_before);
        end

      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && case_entry_q.size() > 0)
        $display("test passed");
      else
        $display("test failed");
      $finish;
    end

endmodule

`default_nettype wire

// File: test/tag_cases.txt
# entry: {op[9:8], client[7:6], dnr[5], payload[4:0]} in hex
# kind: upd, clr, drop (client out of range), nop, wait, done
135 upd
163 upd
1ba upd
000 nop
204 wait
1ef drop
11f clr
200 wait
179 upd
0ff nop
21f wait
18a clr
1a7 upd
1c0 drop
201 wait
12a upd
12c upd
170 upd
203 wait
300 done

// File: filelist.f
verilog/tag_pkg.sv
verilog/tag_trace_replay.sv
verilog/tag_master.sv
verilog/tag_client.sv
verilog/tag_gateway.sv
test/tb_tag_gateway.sv

// File: Makefile
SIM  := obj_dir/Vtb_tag_gateway
SRCS := $(filter-out +%,$(shell cat filelist.f))

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --top-module tb_tag_gateway -f filelist.f -o Vtb_tag_gateway

run: $(SIM) test/tag_cases.txt
	$(SIM) | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
